// File: design/file_dumper.sv
// hex send engine; emits exactly DUMP_LEN bytes per dump, holds all state while tx_ready_i is low
`timescale 1ns/1ns

module file_dumper (
  input  logic                              clk_sys_i,
  input  logic                              rst_clk_i,
  input  logic                              dump_go_i,
  input  logic [3:0]                        file_id_i,
  input  logic                              tx_ready_i,
  input  logic [file_io_pkg::WORD_W-1:0]    rd_data_i,
  output file_io_pkg::byte_beat_t           tx_o,
  output logic [file_io_pkg::ADDR_W-1:0]    rd_addr_o,
  output logic                              dumping_o,
  output logic                              dump_end_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HEAD,   // SOH, name, EOT, SOT
    ST_FETCH,  // one dead cycle for the read port
    ST_ROW,    // digits then CR LF
    ST_TAIL    // EOF
  } state_t;

  state_t state;

  logic [$clog2(file_io_pkg::DUMP_LEN)-1:0]  cnt;      // bytes sent so far
  logic [$clog2(file_io_pkg::ROW_CHARS)-1:0] row_pos;  // char within row
  logic [file_io_pkg::ADDR_W-1:0]            addr_q;
  logic [3:0]                                file_id_q;
  logic [file_io_pkg::WORD_W-1:0]            row_sh;
  logic [7:0]                                tx_char;
  logic                                      tx_valid;
  logic                                      send;     // byte accepted this cycle
  logic                                      row_last;

  assign tx_valid = (state == ST_HEAD) | (state == ST_ROW) | (state == ST_TAIL);
  assign send     = tx_valid & tx_ready_i;
  assign row_last = row_pos == ($clog2(file_io_pkg::ROW_CHARS))'(file_io_pkg::ROW_CHARS - 1);

  // current digit sits at the top after the shift
  assign row_sh = rd_data_i << {row_pos, 2'b00};

  // ************************************************************************
  // character select
  // ************************************************************************
  always_comb begin
    tx_char = 8'h00;
    case (state)
      ST_HEAD: begin
        case (cnt[1:0])
          2'd0:    tx_char = file_io_pkg::SOH_CHAR;
          2'd1:    tx_char = file_io_pkg::nibble_to_hex(file_id_q);  // one-char name
          2'd2:    tx_char = file_io_pkg::EOT_CHAR;
          default: tx_char = file_io_pkg::SOT_CHAR;
        endcase
      end
      ST_ROW: begin
        if (row_pos < file_io_pkg::NIBBLES) begin
          tx_char = file_io_pkg::nibble_to_hex(row_sh[file_io_pkg::WORD_W-1 -: 4]);
        end else if (row_pos == file_io_pkg::NIBBLES) begin
          tx_char = file_io_pkg::CR_CHAR;
        end else begin
          tx_char = file_io_pkg::LF_CHAR;
        end
      end
      ST_TAIL: tx_char = file_io_pkg::EOF_CHAR;
      default: tx_char = 8'h00;
    endcase
  end

  assign tx_o.valid = tx_valid;
  assign tx_o.data  = tx_char;
  assign rd_addr_o  = addr_q;  // held for the whole row, read port keeps re-reading it
  assign dumping_o  = state != ST_IDLE;

  // ************************************************************************
  // sequencing, nothing moves without send
  // ************************************************************************
  always_ff @(posedge clk_sys_i) begin
    if (rst_clk_i) begin
      state      <= ST_IDLE;
      cnt        <= '0;
      row_pos    <= '0;
      addr_q     <= '0;
      dump_end_o <= 1'b0;
    end else begin
      dump_end_o <= 1'b0;
      if (send) cnt <= cnt + 1'b1;
      case (state)
        ST_IDLE: begin
          if (dump_go_i) begin
            state   <= ST_HEAD;
            cnt     <= '0;
            row_pos <= '0;
            addr_q  <= '0;
          end
        end
        ST_HEAD: begin
          if (send && cnt[1:0] == 2'd3) state <= ST_FETCH;
        end
        ST_FETCH: state <= ST_ROW;  // rd_data valid next cycle
        ST_ROW: begin
          if (send) begin
            if (row_last) begin
              row_pos <= '0;
              if (addr_q == file_io_pkg::ADDR_W'(file_io_pkg::MEM_DEPTH - 1)) begin
                state <= ST_TAIL;
              end else begin
                addr_q <= addr_q + 1'b1;
                state  <= ST_FETCH;
              end
            end else begin
              row_pos <= row_pos + 1'b1;
            end
          end
        end
        ST_TAIL: begin
          // EOF is always the last byte of the count
          if (send && cnt == ($clog2(file_io_pkg::DUMP_LEN))'(file_io_pkg::DUMP_LEN - 1)) begin
            state      <= ST_IDLE;
            dump_end_o <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // name char captured at start, later id writes do not disturb a dump
  always_ff @(posedge clk_sys_i) begin
    if (state == ST_IDLE && dump_go_i) begin
      file_id_q <= file_id_i;
    end
  end

endmodule

// File: design/file_io_pkg.sv
// shared defs for the hex file port; one memory of MEM_DEPTH words, 4-bit file id, upper-case hex out
package file_io_pkg;

  // ************************************************************************
  // framing characters
  // ************************************************************************
  localparam logic [7:0] SOH_CHAR = 8'h01;  // start of header
  localparam logic [7:0] EOT_CHAR = 8'h03;  // closes the name field
  localparam logic [7:0] SOT_CHAR = 8'h02;  // start of text
  localparam logic [7:0] EOF_CHAR = 8'h04;  // end of file
  localparam logic [7:0] CR_CHAR  = 8'h0d;
  localparam logic [7:0] LF_CHAR  = 8'h0a;

  // memory geometry
  localparam int MEM_DEPTH = 16;
  localparam int ADDR_W    = 4;
  localparam int NIBBLES   = 8;                            // hex digits per word
  localparam int WORD_W    = 32;
  localparam int ROW_CHARS = NIBBLES + 2;                  // digits plus CR LF
  localparam int DUMP_LEN  = 4 + MEM_DEPTH * ROW_CHARS + 1;  // header, rows, EOF

  // register bus
  localparam int REG_ADDR_W = 2;
  localparam logic [REG_ADDR_W-1:0] CTRL_ADR = 2'd0;
  localparam logic [REG_ADDR_W-1:0] STAT_ADR = 2'd1;

  // ************************************************************************
  // bundles
  // ************************************************************************
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } byte_beat_t;

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [REG_ADDR_W-1:0] adr;
    logic [31:0]           dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] data;
  } mem_wr_t;

  typedef struct packed {
    logic       load_go;  // one-cycle pulses
    logic       dump_go;
    logic [3:0] file_id;
  } xfer_cmd_t;

  typedef struct packed {
    logic loading;
    logic dumping;
    logic load_end;  // one-cycle pulses from the engines
    logic dump_end;
  } xfer_stat_t;

  // hex codec: bit 4 set means not a hex digit
  function automatic logic [4:0] hex_to_nibble(input logic [7:0] ch);
    logic [4:0] res;
    res = 5'b1_0000;
    if (ch >= "0" && ch <= "9") begin
      res = {1'b0, ch[3:0]};
    end else if ((ch >= "A" && ch <= "F") || (ch >= "a" && ch <= "f")) begin
      res = {1'b0, ch[3:0] + 4'h9};  // low nibble of 'A' is 1, so +9 gives 10
    end
    return res;
  endfunction

  function automatic logic [7:0] nibble_to_hex(input logic [3:0] nib);
    if (nib < 4'd10) begin
      return {4'h3, nib};
    end
    return {4'h0, nib} + 8'h37;  // upper case only
  endfunction

endpackage

// File: design/file_io_regs.sv
// wishbone classic regs; single-beat accesses only, ack one cycle after stb, go ignored while busy
`timescale 1ns/1ns

module file_io_regs (
  input  logic                    clk_sys_i,
  input  logic                    rst_clk_i,
  input  file_io_pkg::wb_req_t    wb_req_i,
  input  file_io_pkg::xfer_stat_t stat_i,
  output file_io_pkg::wb_rsp_t    wb_rsp_o,
  output file_io_pkg::xfer_cmd_t  cmd_o
);

  logic        ack_q;
  logic [31:0] rd_dat_q;       // read data, valid with ack
  logic [31:0] rd_mux;
  logic [3:0]  file_id_q;
  logic        load_go_q;
  logic        dump_go_q;
  logic        load_end_q;     // sticky copies of the end pulses
  logic        dump_end_q;
  logic        hit;            // new access, first cycle of stb
  logic        ctrl_wr;
  logic        busy;
  logic        load_go;
  logic        dump_go;

  assign hit     = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign ctrl_wr = hit & wb_req_i.we & (wb_req_i.adr == file_io_pkg::CTRL_ADR);
  assign busy    = stat_i.loading | stat_i.dumping;

  // load wins if both bits are written together
  assign load_go = ctrl_wr & wb_req_i.dat[0] & ~busy;
  assign dump_go = ctrl_wr & wb_req_i.dat[1] & ~wb_req_i.dat[0] & ~busy;

  // read mux, go bits always read 0
  always_comb begin
    rd_mux = 32'h0;
    case (wb_req_i.adr)
      file_io_pkg::CTRL_ADR: rd_mux = {20'h0, file_id_q, 8'h0};
      file_io_pkg::STAT_ADR: rd_mux = {28'h0, dump_end_q, load_end_q,
                                       stat_i.dumping, stat_i.loading};
      default:               rd_mux = 32'h0;  // unused address
    endcase
  end

  // ************************************************************************
  // bus handshake and control state
  // ************************************************************************
  always_ff @(posedge clk_sys_i) begin
    if (rst_clk_i) begin
      ack_q      <= 1'b0;
      file_id_q  <= 4'h0;
      load_go_q  <= 1'b0;
      dump_go_q  <= 1'b0;
      load_end_q <= 1'b0;
      dump_end_q <= 1'b0;
    end else begin
      ack_q     <= hit;        // one ack per access
      load_go_q <= load_go;    // lands in the ack cycle
      dump_go_q <= dump_go;
      if (ctrl_wr) begin
        file_id_q <= wb_req_i.dat[11:8];  // updates even when go is refused
      end
      if (load_go | dump_go) begin
        load_end_q <= 1'b0;
        dump_end_q <= 1'b0;
      end else begin
        if (stat_i.load_end) load_end_q <= 1'b1;
        if (stat_i.dump_end) dump_end_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (hit) begin
      rd_dat_q <= rd_mux;
    end
  end

  assign wb_rsp_o.ack  = ack_q;
  assign wb_rsp_o.dat  = rd_dat_q;
  assign cmd_o.load_go = load_go_q;
  assign cmd_o.dump_go = dump_go_q;
  assign cmd_o.file_id = file_id_q;

endmodule

// File: design/file_io_top.sv
// hex file port top; register bus on wishbone classic, byte streams in valid/ready style
`timescale 1ns/1ns

module file_io_top (
  input  logic                    clk_sys_i,
  input  logic                    rst_clk_i,
  input  file_io_pkg::wb_req_t    wb_req_i,
  output file_io_pkg::wb_rsp_t    wb_rsp_o,
  input  file_io_pkg::byte_beat_t rx_i,
  output logic                    rx_ready_o,
  output file_io_pkg::byte_beat_t tx_o,
  input  logic                    tx_ready_i
);

  file_io_pkg::xfer_cmd_t         cmd;
  file_io_pkg::xfer_stat_t        stat;     // each engine drives its half
  file_io_pkg::mem_wr_t           mem_wr;
  logic [file_io_pkg::ADDR_W-1:0] rd_addr;
  logic [file_io_pkg::WORD_W-1:0] rd_data;

  // register block
  file_io_regs u_regs (
    .clk_sys_i (clk_sys_i),
    .rst_clk_i (rst_clk_i),
    .wb_req_i  (wb_req_i),
    .stat_i    (stat),
    .wb_rsp_o  (wb_rsp_o),
    .cmd_o     (cmd)
  );

  // receive side
  file_loader u_loader (
    .clk_sys_i  (clk_sys_i),
    .rst_clk_i  (rst_clk_i),
    .load_go_i  (cmd.load_go),
    .rx_i       (rx_i),
    .rx_ready_o (rx_ready_o),
    .mem_wr_o   (mem_wr),
    .loading_o  (stat.loading),
    .load_end_o (stat.load_end)
  );

  // send side
  file_dumper u_dumper (
    .clk_sys_i  (clk_sys_i),
    .rst_clk_i  (rst_clk_i),
    .dump_go_i  (cmd.dump_go),
    .file_id_i  (cmd.file_id),
    .tx_ready_i (tx_ready_i),
    .rd_data_i  (rd_data),
    .tx_o       (tx_o),
    .rd_addr_o  (rd_addr),
    .dumping_o  (stat.dumping),
    .dump_end_o (stat.dump_end)
  );

  row_memory u_mem (
    .clk_sys_i (clk_sys_i),
    .wr_i      (mem_wr),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

endmodule

// File: design/file_loader.sv
// hex receive engine; drops bytes until SOT, ignores non-hex chars, stops after MEM_DEPTH words
`timescale 1ns/1ns

module file_loader (
  input  logic                    clk_sys_i,
  input  logic                    rst_clk_i,
  input  logic                    load_go_i,
  input  file_io_pkg::byte_beat_t rx_i,
  output logic                    rx_ready_o,
  output file_io_pkg::mem_wr_t    mem_wr_o,
  output logic                    loading_o,
  output logic                    load_end_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_SOT,  // drop everything until SOT
    ST_LOAD
  } state_t;

  state_t state;

  logic [$clog2(file_io_pkg::NIBBLES)-1:0] nib_cnt;  // digits of current word
  logic [file_io_pkg::ADDR_W-1:0]          addr_q;
  logic [file_io_pkg::WORD_W-1:0]          shift_q;  // partial word
  logic [4:0]                              dec;      // {invalid, nibble}
  logic                                    take;
  logic                                    is_sot;
  logic                                    hex_take;
  logic                                    last_dig;
  logic                                    last_row;

  // ready from the go cycle on, never stalls on its own
  assign rx_ready_o = (state != ST_IDLE) | load_go_i;
  assign take       = rx_i.valid & rx_ready_o;
  assign is_sot     = rx_i.data == file_io_pkg::SOT_CHAR;
  assign dec        = file_io_pkg::hex_to_nibble(rx_i.data);
  assign hex_take   = take & (state == ST_LOAD) & ~dec[4];  // CR LF fall out here too
  assign last_dig   = nib_cnt == ($clog2(file_io_pkg::NIBBLES))'(file_io_pkg::NIBBLES - 1);
  assign last_row   = addr_q == file_io_pkg::ADDR_W'(file_io_pkg::MEM_DEPTH - 1);

  // write goes out on the edge that takes the last digit
  assign mem_wr_o.en   = hex_take & last_dig;
  assign mem_wr_o.addr = addr_q;
  assign mem_wr_o.data = {shift_q[file_io_pkg::WORD_W-5:0], dec[3:0]};

  assign loading_o = state != ST_IDLE;

  // ************************************************************************
  // control
  // ************************************************************************
  always_ff @(posedge clk_sys_i) begin
    if (rst_clk_i) begin
      state      <= ST_IDLE;
      nib_cnt    <= '0;
      addr_q     <= '0;
      load_end_o <= 1'b0;
    end else begin
      load_end_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (load_go_i) begin
            nib_cnt <= '0;
            addr_q  <= '0;
            // SOT may already sit on the stream in the go cycle
            state   <= (take && is_sot) ? ST_LOAD : ST_WAIT_SOT;
          end
        end
        ST_WAIT_SOT: begin
          if (take && is_sot) state <= ST_LOAD;
        end
        ST_LOAD: begin
          if (hex_take) begin
            if (last_dig) begin
              nib_cnt <= '0;
              if (last_row) begin
                state      <= ST_IDLE;
                addr_q     <= '0;
                load_end_o <= 1'b1;  // one cycle after the last write
              end else begin
                addr_q <= addr_q + 1'b1;
              end
            end else begin
              nib_cnt <= nib_cnt + 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // msb first, oldest digit ends up on top
  always_ff @(posedge clk_sys_i) begin
    if (hex_take) begin
      shift_q <= {shift_q[file_io_pkg::WORD_W-5:0], dec[3:0]};
    end
  end

endmodule

// File: design/row_memory.sv
// word memory, one write port, registered read; contents undefined until first load
`timescale 1ns/1ns

module row_memory (
  input  logic                           clk_sys_i,
  input  file_io_pkg::mem_wr_t           wr_i,
  input  logic [file_io_pkg::ADDR_W-1:0] rd_addr_i,
  output logic [file_io_pkg::WORD_W-1:0] rd_data_o
);

  logic [file_io_pkg::WORD_W-1:0] mem [file_io_pkg::MEM_DEPTH];

  // write port
  always_ff @(posedge clk_sys_i) begin
    if (wr_i.en) begin
      mem[wr_i.addr] <= wr_i.data;
    end
  end

  // read port, one cycle latency
  always_ff @(posedge clk_sys_i) begin
    rd_data_o <= mem[rd_addr_i];  // old data on a same-address write
  end

endmodule

// File: file_io_top.f
design/file_io_pkg.sv
design/row_memory.sv
design/file_io_regs.sv
design/file_loader.sv
design/file_dumper.sv
design/file_io_top.sv
verification/file_io_tb.sv

// File: verification/file_io_tb.sv
// testbench for the hex file port; expected dump comes from a shadow memory, waits bounded by TMO
`timescale 1ns/1ns

module file_io_tb;

  localparam int TMO = 4000;  // cycles or polls per wait

  logic                    clk_sys;
  logic                    rst_clk;
  file_io_pkg::wb_req_t    wb_req;
  file_io_pkg::wb_rsp_t    wb_rsp;
  file_io_pkg::byte_beat_t rx;
  logic                    rx_ready;
  file_io_pkg::byte_beat_t tx;
  logic                    tx_ready;

  logic [31:0] shadow [file_io_pkg::MEM_DEPTH];  // expected memory contents
  int          ref_phase;      // 0 idle, 1 wait SOT, 2 load
  int          ref_nib;
  int          ref_addr;
  logic [31:0] ref_word;
  bit          dump_expected;  // tx bytes allowed
  bit          bp_mode;        // random tx back-pressure
  logic [3:0]  dump_fid;
  int          tx_cnt;
  int          errors;
  int          err_mark;
  int          tests_ok;
  int          tests_bad;
  string       test_name;
  logic [31:0] rdat;           // last bus read

  file_io_top u_file_io_top (
    .clk_sys_i  (clk_sys),
    .rst_clk_i  (rst_clk),
    .wb_req_i   (wb_req),
    .wb_rsp_o   (wb_rsp),
    .rx_i       (rx),
    .rx_ready_o (rx_ready),
    .tx_o       (tx),
    .tx_ready_i (tx_ready)
  );

  always #4 clk_sys = ~clk_sys;  // 8 ns period

  // sink side, ready only moves on the falling edge
  always @(negedge clk_sys) begin
    tx_ready <= bp_mode ? ($urandom_range(1) == 1) : 1'b1;
  end

  // ************************************************************************
  // reference model
  // ************************************************************************
  function automatic int hex_value(input logic [7:0] c);
    if (c >= "0" && c <= "9") return c - "0";
    if (c >= "A" && c <= "F") return c - "A" + 10;
    if (c >= "a" && c <= "f") return c - "a" + 10;
    return -1;  // not a digit
  endfunction

  function automatic logic [7:0] hex_char(input logic [3:0] nib);
    return (nib < 10) ? 8'("0" + nib) : 8'("A" + nib - 10);  // upper case
  endfunction

  // expected character at position idx of a dump
  function automatic logic [7:0] dump_byte(input int idx, input logic [3:0] fid);
    int r;
    int p;
    r = (idx - 4) / file_io_pkg::ROW_CHARS;
    p = (idx - 4) % file_io_pkg::ROW_CHARS;
    if (idx == 0) return file_io_pkg::SOH_CHAR;
    if (idx == 1) return hex_char(fid);  // name
    if (idx == 2) return file_io_pkg::EOT_CHAR;
    if (idx == 3) return file_io_pkg::SOT_CHAR;
    if (idx == file_io_pkg::DUMP_LEN - 1) return file_io_pkg::EOF_CHAR;
    if (p == 8) return file_io_pkg::CR_CHAR;
    if (p == 9) return file_io_pkg::LF_CHAR;
    return hex_char(shadow[r][31 - 4*p -: 4]);  // msb digit first
  endfunction

  // follows every accepted rx byte
  task automatic ref_decode(input logic [7:0] b);
    int v;
    v = hex_value(b);
    if (ref_phase == 1 && b == file_io_pkg::SOT_CHAR) begin
      ref_phase = 2;
    end else if (ref_phase == 2 && v >= 0) begin
      ref_word = {ref_word[27:0], 4'(v)};
      ref_nib++;
      if (ref_nib == file_io_pkg::NIBBLES) begin  // word complete
        shadow[ref_addr] = ref_word;
        ref_nib = 0;
        ref_addr++;
        if (ref_addr == file_io_pkg::MEM_DEPTH) ref_phase = 0;
      end
    end
  endtask

  // ************************************************************************
  // bus and stream drivers, all start and end on a falling edge
  // ************************************************************************
  task automatic bus_access(input bit we, input logic [1:0] adr, input logic [31:0] dat);
    int t;
    t = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    @(negedge clk_sys);
    while (!wb_rsp.ack && t < TMO) begin
      @(negedge clk_sys);
      t++;
    end
    if (t != 0) begin  // ack due one cycle after the request
      errors++;
      $display("%s: wishbone ack missing or late at address %0d", test_name, adr);
    end
    rdat   = wb_rsp.dat;
    wb_req = '0;
    @(negedge clk_sys);  // stb low for one cycle so ack drops
  endtask

  task automatic wait_status(input int bit_idx);
    int t;
    t    = 0;
    rdat = '0;
    while (!rdat[bit_idx] && t < TMO) begin
      bus_access(1'b0, file_io_pkg::STAT_ADR, 32'h0);
      t++;
    end
    if (!rdat[bit_idx]) begin
      errors++;
      $display("%s: status bit %0d never got set", test_name, bit_idx);
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    int t;
    t        = 0;
    rx.valid = 1'b1;
    rx.data  = b;
    while (!rx_ready && t < TMO) begin
      @(negedge clk_sys);
      t++;
    end
    if (!rx_ready) begin
      errors++;
      $display("%s: loader never took byte %h", test_name, b);
    end else begin
      ref_decode(b);
    end
    @(negedge clk_sys);  // taken on the rising edge in between
    rx.valid = 1'b0;
  endtask

  // random words, mixed case, optional junk before digits, CR LF between rows
  task automatic send_rows(input bit noisy, input int first, input int last);
    logic [31:0] w;
    logic [7:0]  c;
    for (int r = first; r <= last; r++) begin
      w = $urandom;
      for (int n = 0; n < file_io_pkg::NIBBLES; n++) begin
        if (noisy && $urandom_range(2) == 0) begin
          c = 8'($urandom);
          while (hex_value(c) >= 0) c = 8'($urandom);
          send_byte(c);
        end
        c = hex_char(w[31 - 4*n -: 4]);
        if (c >= "A" && $urandom_range(1) == 1) c = c + 8'h20;
        send_byte(c);
      end
      if (r < file_io_pkg::MEM_DEPTH - 1) begin  // loader goes idle after the last digit
        send_byte(file_io_pkg::CR_CHAR);
        send_byte(file_io_pkg::LF_CHAR);
      end
    end
  endtask

  task automatic arm_load();
    ref_phase = 1;
    ref_nib   = 0;
    ref_addr  = 0;
    bus_access(1'b1, file_io_pkg::CTRL_ADR, 32'h1);
  endtask

  task automatic load_file(input bit noisy);
    logic [7:0] c;
    int         junk;
    junk = $urandom_range(6, 1);
    arm_load();
    for (int i = 0; i < junk; i++) begin  // dropped until SOT
      c = 8'($urandom);
      while (c == file_io_pkg::SOT_CHAR) c = 8'($urandom);
      send_byte(c);
    end
    send_byte(file_io_pkg::SOT_CHAR);
    send_rows(noisy, 0, file_io_pkg::MEM_DEPTH - 1);
    wait_status(2);  // load_end
  endtask

  task automatic run_dump(input logic [3:0] fid, input bit bp);
    dump_fid      = fid;
    tx_cnt        = 0;
    dump_expected = 1'b1;
    bp_mode       = bp;
    bus_access(1'b1, file_io_pkg::CTRL_ADR, {20'h0, fid, 8'h02});
    wait_status(3);  // dump_end
    if (tx_cnt != file_io_pkg::DUMP_LEN) begin
      errors++;
      $display("MISMATCH %s byte count: expected %0d, actual %0d",
               test_name, file_io_pkg::DUMP_LEN, tx_cnt);
    end
    dump_expected = 1'b0;
    bp_mode       = 1'b0;
  endtask

  // compares every accepted tx byte with the model
  always @(posedge clk_sys) begin
    if (!rst_clk && tx.valid && tx_ready) begin
      if (!dump_expected || tx_cnt >= file_io_pkg::DUMP_LEN) begin
        errors++;
        $display("%s: unexpected tx byte %h", test_name, tx.data);
      end else begin
        if (tx.data !== dump_byte(tx_cnt, dump_fid)) begin
          errors++;
          $display("MISMATCH %s byte %0d: expected %h, actual %h",
                   test_name, tx_cnt, dump_byte(tx_cnt, dump_fid), tx.data);
        end
        tx_cnt++;
      end
    end
  end

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic end_test();
    if (errors == err_mark) begin
      tests_ok++;
      $display("test %s: pass", test_name);
    end else begin
      tests_bad++;
      $display("test %s: fail, %0d errors", test_name, errors - err_mark);
    end
  endtask

  // ************************************************************************
  // test sequence
  // ************************************************************************
  initial begin
    clk_sys       = 1'b0;
    rst_clk       = 1'b1;
    wb_req        = '0;
    rx            = '0;
    tx_ready      = 1'b1;
    bp_mode       = 1'b0;
    dump_expected = 1'b0;
    errors        = 0;
    tests_ok      = 0;
    tests_bad     = 0;
    test_name     = "reset";
    void'($urandom(32'h986b_4b78));
    repeat (10) @(posedge clk_sys);
    @(negedge clk_sys);
    rst_clk = 1'b0;

    start_test("reset_regs");
    if (rx_ready !== 1'b0 || tx.valid !== 1'b0) begin
      errors++;
      $display("%s: stream outputs active after reset", test_name);
    end
    bus_access(1'b0, file_io_pkg::STAT_ADR, 32'h0);
    if (rdat !== 32'h0) begin
      errors++;
      $display("MISMATCH %s status: expected %h, actual %h", test_name, 32'h0, rdat);
    end
    bus_access(1'b1, file_io_pkg::CTRL_ADR, 32'h700);  // id only, no go
    bus_access(1'b0, file_io_pkg::CTRL_ADR, 32'h0);
    if (rdat !== 32'h700) begin
      errors++;
      $display("MISMATCH %s control: expected %h, actual %h", test_name, 32'h700, rdat);
    end
    end_test();

    start_test("load_dump");
    load_file(1'b0);
    run_dump(4'ha, 1'b0);
    end_test();

    start_test("skip_chars");
    load_file(1'b1);
    run_dump(4'h3, 1'b0);
    end_test();

    start_test("back_pressure");
    run_dump(4'h3, 1'b1);  // same memory, same bytes expected
    end_test();

    start_test("busy_guard");
    arm_load();
    send_byte(file_io_pkg::SOT_CHAR);
    send_rows(1'b0, 0, 5);
    bus_access(1'b1, file_io_pkg::CTRL_ADR, 32'h202);  // refused, load still running
    bus_access(1'b0, file_io_pkg::STAT_ADR, 32'h0);
    if (rdat[1:0] !== 2'b01) begin
      errors++;
      $display("MISMATCH %s busy status: expected %h, actual %h", test_name, 2'b01, rdat[1:0]);
    end
    send_rows(1'b0, 6, file_io_pkg::MEM_DEPTH - 1);
    wait_status(2);
    bus_access(1'b0, file_io_pkg::STAT_ADR, 32'h0);
    if (rdat[1] !== 1'b0 || tx.valid !== 1'b0) begin
      errors++;
      $display("%s: dump started although the go came during a load", test_name);
    end
    run_dump(4'h2, 1'b0);
    end_test();

    $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
